// File: flist.f
+incdir+include
design/schedulerPkg.sv
design/multiPortRam.sv
design/destinationRam.sv
design/readyTracker.sv
design/issueSelect.sv
design/schedulerTop.sv
dv/schedulerTb.sv

// File: Makefile
# Verilator build and run of the scheduler testbench.

VERILATOR ?= verilator
TOP       ?= schedulerTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation gave no result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/schedulerTb.sv
// ----------------------------------------
// Scheduler testbench
// Table-driven dispatch, issue and flush checks.
// ----------------------------------------

`timescale 1ns/100ps

`include "scheduler_cfg.svh"

module schedulerTb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS     = 60;
    // Written at the next edge, granted one edge later, registered the edge after.
    localparam int ISSUE_DELAY  = 3;
    // Wakeup sets the source flag at the next edge, then the ready-op path follows.
    localparam int WAKE_DELAY   = 3;
    localparam int WATCHDOG_NS  =
        (NUM_ROWS * 20 + `SCHED_ENTRY_NUM + RESET_CYCLES) * CLK_PERIOD;

    // One table row per cycle, applied on the falling edge.
    typedef struct packed {
        schedulerPkg::DispatchOp [`SCHED_DISPATCH_WIDTH-1:0] disp;
        logic                                                flush;
        schedulerPkg::IssuedOp   [`SCHED_ISSUE_WIDTH-1:0]    expIssue;
        logic                                                expReady;
    } CycleRow;

    logic                    clk;
    logic                    rstN;
    logic                    flush;
    schedulerPkg::DispatchOp dispatch [`SCHED_DISPATCH_WIDTH];
    schedulerPkg::IssuedOp   issue    [`SCHED_ISSUE_WIDTH];
    logic                    schedReady;

    CycleRow rowTab [NUM_ROWS];
    integer  seed;
    int      errorCount;
    int      checkCount;
    int      sweepCycles;

    schedulerTop schedulerTop_inst (
        .clk       (clk),
        .rstN      (rstN),
        .flush     (flush),
        .dispatch  (dispatch),
        .issue     (issue),
        .schedReady(schedReady)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    // Fills one dispatch lane; a negative issueRow marks an op that never issues.
    task automatic addOp(input int row, input int lane, input int idx, input int dst,
                         input int src0, input bit rdy0, input int src1, input bit rdy1,
                         input int issueRow, input int issueLane);
        schedulerPkg::OpId id;
        id = schedulerPkg::OpId'($random(seed));
        rowTab[row].disp[lane] = '{
            valid:  1'b1,
            index:  schedulerPkg::IqIndex'(idx),
            dstTag: schedulerPkg::RegTag'(dst),
            src0:   '{tag: schedulerPkg::RegTag'(src0), ready: rdy0},
            src1:   '{tag: schedulerPkg::RegTag'(src1), ready: rdy1},
            opId:   id
        };
        if (issueRow >= 0) begin
            rowTab[issueRow].expIssue[issueLane] = '{
                valid:  1'b1,
                opId:   id,
                dstTag: schedulerPkg::RegTag'(dst)
            };
        end
    endtask

    // Sweep begins at the edge that samples flush and lasts one cycle per entry.
    task automatic addFlush(input int row);
        rowTab[row].flush = 1'b1;
        for (int r = row + 1; r <= row + `SCHED_ENTRY_NUM; r++) begin
            rowTab[r].expReady = 1'b0;
        end
    endtask

    task automatic buildTable();
        for (int r = 0; r < NUM_ROWS; r++) begin
            rowTab[r] = '0;
            rowTab[r].expReady = 1'b1;
        end
        // Single ready op.
        addOp(0, 0, 3, 10, 1, 1, 2, 1, ISSUE_DELAY, 0);
        // Pair in one cycle. Slot 5 is lower, so it lands on lane 0.
        addOp(6, 0, 9, 11, 1, 1, 2, 1, 6 + ISSUE_DELAY, 1);
        addOp(6, 1, 5, 12, 1, 1, 2, 1, 6 + ISSUE_DELAY, 0);
        // Five ops, two per cycle, the last one alone.
        addOp(12, 0, 6, 13, 1, 1, 2, 1, 12 + ISSUE_DELAY, 1);
        addOp(12, 1, 1, 14, 1, 1, 2, 1, 12 + ISSUE_DELAY, 0);
        addOp(13, 0, 11, 15, 1, 1, 2, 1, 13 + ISSUE_DELAY, 1);
        addOp(13, 1, 8, 16, 1, 1, 2, 1, 13 + ISSUE_DELAY, 0);
        addOp(14, 0, 14, 17, 1, 1, 2, 1, 14 + ISSUE_DELAY, 0);
        // Producer of tag 20 and an early consumer waiting on it.
        addOp(20, 0, 2, 20, 1, 1, 2, 1, 20 + ISSUE_DELAY, 0);
        addOp(20, 1, 4, 21, 20, 0, 2, 1, 20 + ISSUE_DELAY + WAKE_DELAY, 0);
        // Late consumer, dispatched in the producer's issue cycle.
        addOp(20 + ISSUE_DELAY, 0, 10, 22, 1, 1, 20, 0, 20 + 2 * ISSUE_DELAY, 1);
        // Two entries wait on tag 32, which the op granted at the flush edge wakes.
        addOp(30, 0, 0, 30, 32, 0, 2, 1, -1, 0);
        addOp(30, 1, 15, 31, 1, 1, 32, 0, -1, 0);
        addOp(31, 0, 7, 32, 1, 1, 2, 1, 31 + ISSUE_DELAY, 0);
        addFlush(32);
        // Old slots reused with new tags after the sweep.
        addOp(50, 0, 0, 40, 1, 1, 2, 1, 50 + ISSUE_DELAY, 0);
        addOp(50, 1, 15, 41, 1, 1, 2, 1, 50 + ISSUE_DELAY, 1);
    endtask

    task automatic checkIdle();
        for (int k = 0; k < `SCHED_ISSUE_WIDTH; k++) begin
            checkValue($sformatf("issue[%0d].valid", k), 32'(issue[k].valid), 32'd0);
        end
    endtask

    task automatic checkRow(input int r);
        schedulerPkg::IssuedOp expOp;
        checkValue("schedReady", 32'(schedReady), 32'(rowTab[r].expReady));
        for (int k = 0; k < `SCHED_ISSUE_WIDTH; k++) begin
            expOp = rowTab[r].expIssue[k];
            checkValue($sformatf("issue[%0d].valid", k), 32'(issue[k].valid),
                       32'(expOp.valid));
            // Payload only matters on a valid lane.
            if (expOp.valid) begin
                checkValue($sformatf("issue[%0d].opId", k), 32'(issue[k].opId),
                           32'(expOp.opId));
                checkValue($sformatf("issue[%0d].dstTag", k), 32'(issue[k].dstTag),
                           32'(expOp.dstTag));
            end
        end
    endtask

    task automatic driveRow(input int r);
        for (int d = 0; d < `SCHED_DISPATCH_WIDTH; d++) begin
            dispatch[d] = rowTab[r].disp[d];
        end
        flush = rowTab[r].flush;
    endtask

    initial begin
        seed       = 32'h77d0;
        errorCount = 0;
        checkCount = 0;
        rstN       = 1'b0;
        flush      = 1'b0;
        for (int d = 0; d < `SCHED_DISPATCH_WIDTH; d++) begin
            dispatch[d] = '0;
        end
        buildTable();

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkIdle();
            checkValue("schedReady", 32'(schedReady), 32'd0);
        end
        rstN = 1'b1;

        // Sweep after reset release.
        sweepCycles = 0;
        do begin
            @(negedge clk);
            sweepCycles++;
            checkIdle();
        end while (!schedReady);
        checkValue("sweep cycles", 32'(sweepCycles), 32'(`SCHED_ENTRY_NUM));

        for (int r = 0; r < NUM_ROWS; r++) begin
            checkRow(r);
            driveRow(r);
            @(negedge clk);
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: design/schedulerTop.sv
// --------------------------------------
// Scheduler top
// Wakeup/select core: tracker, selector, RAMs and issue register.
// --------------------------------------

`timescale 1ns/100ps

`include "scheduler_cfg.svh"

module schedulerTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    flush,
    input  schedulerPkg::DispatchOp dispatch [`SCHED_DISPATCH_WIDTH],
    output schedulerPkg::IssuedOp   issue    [`SCHED_ISSUE_WIDTH],
    output logic                    schedReady
);

    logic [`SCHED_ENTRY_NUM-1:0] request;
    logic                         sweeping;
    schedulerPkg::IssueGrant      grant       [`SCHED_ISSUE_WIDTH];
    schedulerPkg::RegTag          grantDstTag [`SCHED_ISSUE_WIDTH];
    schedulerPkg::OpId            grantOpId   [`SCHED_ISSUE_WIDTH];
    schedulerPkg::WakeupTag       wakeup      [`SCHED_ISSUE_WIDTH];

    logic                 payloadWe   [`SCHED_DISPATCH_WIDTH];
    schedulerPkg::IqIndex payloadAddr [`SCHED_DISPATCH_WIDTH];
    schedulerPkg::OpId    payloadData [`SCHED_DISPATCH_WIDTH];
    schedulerPkg::IqIndex payloadRa   [`SCHED_ISSUE_WIDTH];

    assign schedReady = !sweeping;

    always_comb begin
        for (int d = 0; d < `SCHED_DISPATCH_WIDTH; d++) begin
            payloadWe[d]   = dispatch[d].valid && !sweeping;
            payloadAddr[d] = dispatch[d].index;
            payloadData[d] = dispatch[d].opId;
        end
        for (int k = 0; k < `SCHED_ISSUE_WIDTH; k++) begin
            payloadRa[k] = grant[k].index;
            // Issued destination tags double as wakeups.
            wakeup[k].valid = issue[k].valid;
            wakeup[k].tag   = issue[k].dstTag;
        end
    end

    readyTracker tracker (
        .clk     (clk),
        .rstN    (rstN),
        .flush   (flush),
        .sweeping(sweeping),
        .dispatch(dispatch),
        .grant   (grant),
        .wakeup  (wakeup),
        .request (request)
    );

    issueSelect selector (
        .clk    (clk),
        .rstN   (rstN),
        .request(request),
        .grant  (grant)
    );

    destinationRam dstRam (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (flush),
        .dispatch   (dispatch),
        .grant      (grant),
        .grantDstTag(grantDstTag),
        .sweeping   (sweeping)
    );

    multiPortRam #(
        .ENTRY_NUM(`SCHED_ENTRY_NUM),
        .READ_NUM (`SCHED_ISSUE_WIDTH),
        .WRITE_NUM(`SCHED_DISPATCH_WIDTH),
        .EntryT   (schedulerPkg::OpId)
    ) payloadRam (
        .clk(clk),
        .we (payloadWe),
        .wa (payloadAddr),
        .wv (payloadData),
        .ra (payloadRa),
        .rv (grantOpId)
    );

    // Issue register.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < `SCHED_ISSUE_WIDTH; k++) begin
                issue[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `SCHED_ISSUE_WIDTH; k++) begin
                issue[k].valid  <= grant[k].valid;
                issue[k].opId   <= grantOpId[k];
                issue[k].dstTag <= grantDstTag[k];
            end
        end
    end

endmodule

// File: design/issueSelect.sv
// --------------------------------------
// Issue select
// Grants the lowest requesting entries, one per issue lane.
// --------------------------------------

`timescale 1ns/100ps

`include "scheduler_cfg.svh"

module issueSelect (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [`SCHED_ENTRY_NUM-1:0] request,
    output schedulerPkg::IssueGrant      grant [`SCHED_ISSUE_WIDTH]
);

    schedulerPkg::IssueGrant pick [`SCHED_ISSUE_WIDTH];

    // Scan upward; each hit fills the next free lane.
    always_comb begin
        int laneCnt;
        laneCnt = 0;
        for (int k = 0; k < `SCHED_ISSUE_WIDTH; k++) begin
            pick[k] = '0;
        end
        for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
            if (request[i] && (laneCnt < `SCHED_ISSUE_WIDTH)) begin
                pick[laneCnt].valid = 1'b1;
                pick[laneCnt].index = schedulerPkg::IqIndex'(i);
                laneCnt++;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < `SCHED_ISSUE_WIDTH; k++) begin
                grant[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `SCHED_ISSUE_WIDTH; k++) begin
                grant[k] <= pick[k];
            end
        end
    end

    // Same slot on two lanes would issue one op twice.
    for (genvar a = 0; a < `SCHED_ISSUE_WIDTH; a++) begin : gLaneCheckA
        for (genvar b = a + 1; b < `SCHED_ISSUE_WIDTH; b++) begin : gLaneCheckB
            distinctGrant: assert property (
                @(posedge clk) disable iff (!rstN)
                (grant[a].valid && grant[b].valid) |-> (grant[a].index != grant[b].index)
            ) else $error("issueSelect: lanes %0d and %0d share slot %0d",
                          a, b, grant[a].index);
        end
    end

endmodule

// File: design/readyTracker.sv
// --------------------------------------
// Ready tracker
// Per-entry valid and source state, wakeup match, request vector.
// --------------------------------------

`timescale 1ns/100ps

`include "scheduler_cfg.svh"

module readyTracker (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         flush,
    input  logic                         sweeping,
    input  schedulerPkg::DispatchOp      dispatch [`SCHED_DISPATCH_WIDTH],
    input  schedulerPkg::IssueGrant      grant    [`SCHED_ISSUE_WIDTH],
    input  schedulerPkg::WakeupTag       wakeup   [`SCHED_ISSUE_WIDTH],
    output logic [`SCHED_ENTRY_NUM-1:0] request
);

    logic [`SCHED_ENTRY_NUM-1:0] entryValid;
    logic [`SCHED_ENTRY_NUM-1:0] nextValid;
    logic [`SCHED_ENTRY_NUM-1:0] grantMask;
    logic [`SCHED_ENTRY_NUM-1:0] dispatchMask;
    logic [`SCHED_ENTRY_NUM-1:0] bothReady;

    // Index 0 and 1 are the two sources.
    schedulerPkg::SrcOperand srcState [`SCHED_ENTRY_NUM][2];

    // True when any live wakeup lane carries this tag.
    function automatic logic wakeupHit(schedulerPkg::RegTag tag);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < `SCHED_ISSUE_WIDTH; k++) begin
            if (wakeup[k].valid && (wakeup[k].tag == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        grantMask    = '0;
        dispatchMask = '0;
        for (int k = 0; k < `SCHED_ISSUE_WIDTH; k++) begin
            if (grant[k].valid) begin
                grantMask[grant[k].index] = 1'b1;
            end
        end
        for (int d = 0; d < `SCHED_DISPATCH_WIDTH; d++) begin
            if (dispatch[d].valid && !sweeping) begin
                dispatchMask[dispatch[d].index] = 1'b1;
            end
        end
        for (int e = 0; e < `SCHED_ENTRY_NUM; e++) begin
            bothReady[e] = srcState[e][0].ready && srcState[e][1].ready;
        end
        nextValid = (entryValid & ~grantMask) | dispatchMask;
        // Entries granted last edge are masked until they are cleared.
        request = entryValid & bothReady & ~grantMask;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
        end else if (flush) begin
            entryValid <= '0;
        end else begin
            entryValid <= nextValid;
        end
    end

    // Wakeups set flags; a new dispatch overwrites its slot.
    always_ff @(posedge clk) begin
        for (int e = 0; e < `SCHED_ENTRY_NUM; e++) begin
            for (int s = 0; s < 2; s++) begin
                srcState[e][s].ready <= srcState[e][s].ready | wakeupHit(srcState[e][s].tag);
            end
        end
        for (int d = 0; d < `SCHED_DISPATCH_WIDTH; d++) begin
            if (dispatch[d].valid && !sweeping) begin
                srcState[dispatch[d].index][0] <= '{
                    tag:   dispatch[d].src0.tag,
                    ready: dispatch[d].src0.ready | wakeupHit(dispatch[d].src0.tag)
                };
                srcState[dispatch[d].index][1] <= '{
                    tag:   dispatch[d].src1.tag,
                    ready: dispatch[d].src1.ready | wakeupHit(dispatch[d].src1.tag)
                };
            end
        end
    end

    // Dispatcher owns the slots, so it must pick free ones and respect the sweep.
    for (genvar d = 0; d < `SCHED_DISPATCH_WIDTH; d++) begin : gDispatchCheck
        dispatchToFree: assert property (
            @(posedge clk) disable iff (!rstN)
            dispatch[d].valid |-> !entryValid[dispatch[d].index]
        ) else $error("readyTracker: lane %0d dispatches into busy slot", d);

        noDispatchInSweep: assert property (
            @(posedge clk) disable iff (!rstN)
            sweeping |-> !dispatch[d].valid
        ) else $error("readyTracker: lane %0d dispatches during sweep", d);
    end

endmodule

// File: design/destinationRam.sv
// --------------------------------------
// Destination-tag table
// Read with grant indices; cleared by a sweep after reset or flush.
// --------------------------------------

`timescale 1ns/100ps

`include "scheduler_cfg.svh"

module destinationRam (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    flush,
    input  schedulerPkg::DispatchOp dispatch    [`SCHED_DISPATCH_WIDTH],
    input  schedulerPkg::IssueGrant grant       [`SCHED_ISSUE_WIDTH],
    output schedulerPkg::RegTag     grantDstTag [`SCHED_ISSUE_WIDTH],
    output logic                    sweeping
);

    logic                 ramWe   [`SCHED_DISPATCH_WIDTH];
    schedulerPkg::IqIndex ramAddr [`SCHED_DISPATCH_WIDTH];
    schedulerPkg::RegTag  ramData [`SCHED_DISPATCH_WIDTH];
    schedulerPkg::IqIndex readPtr [`SCHED_ISSUE_WIDTH];
    schedulerPkg::IqIndex sweepCnt;

    // Sweep starts out of reset and again on every flush.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sweeping <= 1'b1;
            sweepCnt <= '0;
        end else if (flush) begin
            sweeping <= 1'b1;
            sweepCnt <= '0;
        end else if (sweeping) begin
            sweepCnt <= sweepCnt + 1'b1;
            if (sweepCnt == schedulerPkg::IqIndex'(`SCHED_ENTRY_NUM - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SCHED_DISPATCH_WIDTH; i++) begin
            ramWe[i]   = dispatch[i].valid;
            ramAddr[i] = dispatch[i].index;
            ramData[i] = dispatch[i].dstTag;
        end

        // Sweep takes port 0 and silences the rest.
        if (sweeping) begin
            for (int i = 0; i < `SCHED_DISPATCH_WIDTH; i++) begin
                ramWe[i] = 1'b0;
            end
            ramWe[0]   = 1'b1;
            ramAddr[0] = sweepCnt;
            ramData[0] = '0;
        end

        for (int i = 0; i < `SCHED_ISSUE_WIDTH; i++) begin
            readPtr[i] = grant[i].index;
        end
    end

    multiPortRam #(
        .ENTRY_NUM(`SCHED_ENTRY_NUM),
        .READ_NUM (`SCHED_ISSUE_WIDTH),
        .WRITE_NUM(`SCHED_DISPATCH_WIDTH),
        .EntryT   (schedulerPkg::RegTag)
    ) dstRam (
        .clk(clk),
        .we (ramWe),
        .wa (ramAddr),
        .wv (ramData),
        .ra (readPtr),
        .rv (grantDstTag)
    );

endmodule

// File: design/multiPortRam.sv
// --------------------------------------
// Multi-port distributed RAM
// Flop storage, several write ports, combinational reads.
// --------------------------------------

`timescale 1ns/100ps

module multiPortRam #(
    parameter int  ENTRY_NUM = 16,
    parameter int  READ_NUM  = 2,
    parameter int  WRITE_NUM = 2,
    parameter type EntryT    = logic [7:0]
) (
    input  logic                 clk,
    input  logic                 we [WRITE_NUM],
    input  schedulerPkg::IqIndex wa [WRITE_NUM],
    input  EntryT                wv [WRITE_NUM],
    input  schedulerPkg::IqIndex ra [READ_NUM],
    output EntryT                rv [READ_NUM]
);

    EntryT mem [ENTRY_NUM];

    // Ports are applied in order, so the highest enabled port wins.
    always_ff @(posedge clk) begin
        for (int i = 0; i < WRITE_NUM; i++) begin
            if (we[i]) begin
                mem[wa[i]] <= wv[i];
            end
        end
    end

    // Reads see the contents before this cycle's writes.
    always_comb begin
        for (int i = 0; i < READ_NUM; i++) begin
            rv[i] = mem[ra[i]];
        end
    end

    // Two lanes hitting one slot means the caller lost track of its indices.
    for (genvar i = 0; i < WRITE_NUM; i++) begin : gWriteCheckA
        for (genvar j = i + 1; j < WRITE_NUM; j++) begin : gWriteCheckB
            writeConflict: assert property (
                @(posedge clk) !(we[i] && we[j] && (wa[i] == wa[j]))
            ) else $error("multiPortRam: ports %0d and %0d write slot %0d", i, j, wa[i]);
        end
    end

endmodule

// File: design/schedulerPkg.sv
// --------------------------------------
// Scheduler types
// Index, tag and lane structs of the wakeup/select core.
// --------------------------------------

`include "scheduler_cfg.svh"

package schedulerPkg;

    // Slot number in the issue queue.
    typedef logic [$clog2(`SCHED_ENTRY_NUM)-1:0] IqIndex;

    // Physical-register tag.
    typedef logic [`SCHED_TAG_BITS-1:0] RegTag;

    // Identifier returned with the issued op.
    typedef logic [`SCHED_OPID_BITS-1:0] OpId;

    typedef struct packed {
        RegTag tag;
        logic  ready;
    } SrcOperand;

    // One dispatch lane.
    typedef struct packed {
        logic      valid;
        IqIndex    index;
        RegTag     dstTag;
        SrcOperand src0;
        SrcOperand src1;
        OpId       opId;
    } DispatchOp;

    typedef struct packed {
        logic   valid;
        IqIndex index;
    } IssueGrant;

    // Broadcast from the issue stage back to the tracker.
    typedef struct packed {
        logic  valid;
        RegTag tag;
    } WakeupTag;

    typedef struct packed {
        logic  valid;
        OpId   opId;
        RegTag dstTag;
    } IssuedOp;

endpackage

// File: include/scheduler_cfg.svh
// --------------------------------------
// Scheduler configuration
// Sizes of the issue queue, lanes and tags.
// --------------------------------------

`ifndef SCHEDULER_CFG_SVH
`define SCHEDULER_CFG_SVH

// Issue-queue entries.
`define SCHED_ENTRY_NUM 16

// Ops written into the queue per cycle.
`define SCHED_DISPATCH_WIDTH 2

// Grants per cycle, also the number of wakeup lanes.
`define SCHED_ISSUE_WIDTH 2

// Physical-register tag width.
`define SCHED_TAG_BITS 6

// Op identifier width.
`define SCHED_OPID_BITS 8

`endif
